/* Makefile */
# Verilator build and run of the SBA subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_dm_sba
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+include
hdl/sba_pkg.sv
hdl/sba_bus_if.sv
hdl/dm_sba_regs.sv
hdl/sba_fsm.sv
hdl/sba_addr_counter.sv
hdl/sba_sram.sv
hdl/dm_sba_top.sv
verif/tb_dm_sba.sv

/* hdl/dm_sba_regs.sv */
// SBA register block
// decodes DMI accesses to SBCS, SBAddress0 and SBData0, starts system bus
// reads and writes, and keeps the sticky busy and address errors

`timescale 1ns/10ps
`default_nettype none
`include "sba_config.svh"

module dm_sba_regs (
   input  logic                clk_sys,
   input  logic                rst_n_i,
   input  logic                dmi_req_i,
   input  logic                dmi_we_i,
   input  sba_pkg::dmi_addr_t  dmi_addr_i,
   input  sba_pkg::sba_word_t  dmi_wdata_i,
   output sba_pkg::sba_word_t  dmi_rdata_o,
   output logic                dmi_rvalid_o,
   input  logic                busy_i,
   input  sba_pkg::sba_addr_t  addr_i,
   output logic                start_read_o,
   output logic                start_write_o,
   output logic                addr_load_o,
   output sba_pkg::sba_addr_t  addr_wdata_o,
   output logic                autoinc_o,
   sba_bus_if.data             bus
);

   localparam sba_pkg::sba_addr_t mem_bytes = `SBA_MEM_WORDS * 4;

   logic               wr_sbcs;
   logic               wr_sbaddr;
   logic               wr_sbdata;
   logic               rd_sbdata;
   logic               trig_read;
   logic               trig_write;
   logic               addr_ok;
   sba_pkg::sba_addr_t check_addr;
   sba_pkg::sba_word_t sbcs_value;

   logic               readonaddr_q;
   logic               readondata_q;
   logic               autoinc_q;
   logic               busyerror_q;
   logic               sberror_q;
   logic               read_pend_q;
   logic               start_read_q;
   logic               start_write_q;
   logic               rvalid_q;
   sba_pkg::sba_word_t sbdata_q;
   sba_pkg::sba_word_t rdata_q;

   assign wr_sbcs   = dmi_req_i && dmi_we_i && (dmi_addr_i == sba_pkg::SBCS);
   assign wr_sbaddr = dmi_req_i && dmi_we_i && (dmi_addr_i == sba_pkg::SBADDRESS0);
   assign wr_sbdata = dmi_req_i && dmi_we_i && (dmi_addr_i == sba_pkg::SBDATA0);
   assign rd_sbdata = dmi_req_i && !dmi_we_i && (dmi_addr_i == sba_pkg::SBDATA0);

   assign trig_write = wr_sbdata;
   assign trig_read  = (wr_sbaddr && readonaddr_q) || (rd_sbdata && readondata_q);

   // read on address targets the new address, everything else the current one
   assign check_addr = wr_sbaddr ? sba_pkg::sba_addr_t'(dmi_wdata_i) : addr_i;
   assign addr_ok    = (check_addr[1:0] == 2'b00) && (check_addr < mem_bytes);

   always_comb begin
      sbcs_value         = '0;
      sbcs_value[31:29]  = 3'd1;
      sbcs_value[22]     = busyerror_q;
      sbcs_value[21]     = busy_i;
      sbcs_value[20]     = readonaddr_q;
      sbcs_value[19:17]  = 3'd2;
      sbcs_value[16]     = autoinc_q;
      sbcs_value[15]     = readondata_q;
      // bad address code
      sbcs_value[14:12]  = {1'b0, sberror_q, 1'b0};
      sbcs_value[11:5]   = 7'(`SBA_ADDR_W);
      sbcs_value[2]      = 1'b1;
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         readonaddr_q  <= 1'b0;
         readondata_q  <= 1'b0;
         autoinc_q     <= 1'b0;
         busyerror_q   <= 1'b0;
         sberror_q     <= 1'b0;
         read_pend_q   <= 1'b0;
         start_read_q  <= 1'b0;
         start_write_q <= 1'b0;
         rvalid_q      <= 1'b0;
      end else begin
         start_read_q  <= trig_read && !busy_i && addr_ok;
         start_write_q <= trig_write && !busy_i && addr_ok;
         rvalid_q      <= dmi_req_i && !dmi_we_i;

         if (wr_sbcs) begin
            readonaddr_q <= dmi_wdata_i[20];
            autoinc_q    <= dmi_wdata_i[16];
            readondata_q <= dmi_wdata_i[15];
            // write one to clear
            if (dmi_wdata_i[22]) begin
               busyerror_q <= 1'b0;
            end
            if (|dmi_wdata_i[14:12]) begin
               sberror_q <= 1'b0;
            end
         end

         if (busy_i && (wr_sbaddr || wr_sbdata || trig_read)) begin
            busyerror_q <= 1'b1;
         end
         if (!busy_i && (trig_read || trig_write) && !addr_ok) begin
            sberror_q <= 1'b1;
         end

         if (trig_read && !busy_i && addr_ok) begin
            read_pend_q <= 1'b1;
         end else if (bus.mem_rvalid) begin
            read_pend_q <= 1'b0;
         end
      end
   end

   // data register, written by DMI or by a finished read
   always_ff @(posedge clk_sys) begin
      if (wr_sbdata && !busy_i) begin
         sbdata_q <= dmi_wdata_i;
      end else if (read_pend_q && bus.mem_rvalid) begin
         sbdata_q <= bus.mem_rdata;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_req_i && !dmi_we_i) begin
         case (dmi_addr_i)
            sba_pkg::SBCS:       rdata_q <= sbcs_value;
            sba_pkg::SBADDRESS0: rdata_q <= sba_pkg::sba_word_t'(addr_i);
            sba_pkg::SBDATA0:    rdata_q <= sbdata_q;
            default:             rdata_q <= '0;
         endcase
      end
   end

   assign dmi_rdata_o   = rdata_q;
   assign dmi_rvalid_o  = rvalid_q;
   assign start_read_o  = start_read_q;
   assign start_write_o = start_write_q;
   assign addr_load_o   = wr_sbaddr && !busy_i;
   assign addr_wdata_o  = sba_pkg::sba_addr_t'(dmi_wdata_i);
   assign autoinc_o     = autoinc_q;
   assign bus.mem_wdata = sbdata_q;

   a_start_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      !(start_read_q && start_write_q));

endmodule

`default_nettype wire

/* hdl/dm_sba_top.sv */
// debug module system bus access top level
// DMI register block, access sequencer, address register and preload SRAM

`timescale 1ns/10ps
`default_nettype none

module dm_sba_top (
   input  logic               clk_sys,
   input  logic               rst_n_i,
   input  logic               dmi_req_i,
   input  logic               dmi_we_i,
   input  sba_pkg::dmi_addr_t dmi_addr_i,
   input  sba_pkg::sba_word_t dmi_wdata_i,
   output sba_pkg::sba_word_t dmi_rdata_o,
   output logic               dmi_rvalid_o
);

   logic               start_read;
   logic               start_write;
   logic               busy;
   logic               done;
   logic               addr_load;
   logic               autoinc;
   sba_pkg::sba_addr_t addr_wdata;
   sba_pkg::sba_addr_t addr;

   sba_bus_if bus0 ();

   dm_sba_regs regs0 (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n_i),
      .dmi_req_i     (dmi_req_i),
      .dmi_we_i      (dmi_we_i),
      .dmi_addr_i    (dmi_addr_i),
      .dmi_wdata_i   (dmi_wdata_i),
      .dmi_rdata_o   (dmi_rdata_o),
      .dmi_rvalid_o  (dmi_rvalid_o),
      .busy_i        (busy),
      .addr_i        (addr),
      .start_read_o  (start_read),
      .start_write_o (start_write),
      .addr_load_o   (addr_load),
      .addr_wdata_o  (addr_wdata),
      .autoinc_o     (autoinc),
      .bus           (bus0.data)
   );

   sba_fsm fsm0 (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n_i),
      .start_read_i  (start_read),
      .start_write_i (start_write),
      .busy_o        (busy),
      .done_o        (done),
      .bus           (bus0.ctrl)
   );

   sba_addr_counter addr0 (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n_i),
      .addr_load_i  (addr_load),
      .addr_wdata_i (addr_wdata),
      .autoinc_i    (autoinc),
      .done_i       (done),
      .addr_o       (addr),
      .bus          (bus0.addr)
   );

   sba_sram sram0 (
      .clk_sys (clk_sys),
      .rst_n_i (rst_n_i),
      .bus     (bus0.mem)
   );

endmodule

`default_nettype wire

/* hdl/sba_addr_counter.sv */
// SBA address register
// loaded from SBAddress0 and stepped by one word after each access
// when autoincrement is on

`timescale 1ns/10ps
`default_nettype none
`include "sba_config.svh"

module sba_addr_counter (
   input  logic               clk_sys,
   input  logic               rst_n_i,
   input  logic               addr_load_i,
   input  sba_pkg::sba_addr_t addr_wdata_i,
   input  logic               autoinc_i,
   input  logic               done_i,
   output sba_pkg::sba_addr_t addr_o,
   sba_bus_if.addr            bus
);

   localparam sba_pkg::sba_addr_t word_bytes = `SBA_DATA_W / 8;

   sba_pkg::sba_addr_t addr_q;

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         addr_q <= '0;
      end else if (addr_load_i) begin
         addr_q <= addr_wdata_i;
      end else if (done_i && autoinc_i) begin
         addr_q <= addr_q + word_bytes;
      end
   end

   assign addr_o       = addr_q;
   assign bus.mem_addr = addr_q;

endmodule

`default_nettype wire

/* hdl/sba_bus_if.sv */
// SBA memory bus
// single-cycle request from the SBA control blocks to the SRAM, with a
// response strobe one cycle later

`timescale 1ns/10ps
`default_nettype none
`include "sba_config.svh"

interface sba_bus_if;

   logic               mem_req;
   logic               mem_we;
   sba_pkg::sba_addr_t mem_addr;
   sba_pkg::sba_word_t mem_wdata;
   sba_pkg::sba_word_t mem_rdata;
   logic               mem_rvalid;

   // access sequencing
   modport ctrl (output mem_req, output mem_we, input mem_rvalid);

   // address source
   modport addr (output mem_addr);

   // write data source and read data sink
   modport data (output mem_wdata, input mem_rdata, input mem_rvalid);

   modport mem (
      input  mem_req,
      input  mem_we,
      input  mem_addr,
      input  mem_wdata,
      output mem_rdata,
      output mem_rvalid
   );

endinterface

`default_nettype wire

/* hdl/sba_fsm.sv */
// SBA access sequencer
// runs one system bus access from a start pulse to the memory response
// and reports busy and done

`timescale 1ns/10ps
`default_nettype none

module sba_fsm (
   input  logic    clk_sys,
   input  logic    rst_n_i,
   input  logic    start_read_i,
   input  logic    start_write_i,
   output logic    busy_o,
   output logic    done_o,
   sba_bus_if.ctrl bus
);

   sba_pkg::sba_state_e state_q;
   sba_pkg::sba_state_e state_d;
   logic                we_q;
   logic                start;

   assign start = start_read_i || start_write_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         sba_pkg::SBA_IDLE: begin
            if (start) begin
               state_d = sba_pkg::SBA_REQ;
            end
         end
         sba_pkg::SBA_REQ: state_d = sba_pkg::SBA_WAIT;
         sba_pkg::SBA_WAIT: begin
            if (bus.mem_rvalid) begin
               state_d = sba_pkg::SBA_IDLE;
            end
         end
         default: state_d = sba_pkg::SBA_IDLE;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         state_q <= sba_pkg::SBA_IDLE;
         we_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         // direction held for the whole access
         if (state_q == sba_pkg::SBA_IDLE && start) begin
            we_q <= start_write_i;
         end
      end
   end

   assign bus.mem_req = (state_q == sba_pkg::SBA_REQ);
   assign bus.mem_we  = (state_q == sba_pkg::SBA_REQ) && we_q;

   // busy already in the start cycle
   assign busy_o = (state_q != sba_pkg::SBA_IDLE) || start;
   assign done_o = (state_q == sba_pkg::SBA_WAIT) && bus.mem_rvalid;

   a_rvalid_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      bus.mem_rvalid |-> state_q == sba_pkg::SBA_WAIT);

   a_start_when_idle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      start |-> state_q == sba_pkg::SBA_IDLE);

endmodule

`default_nettype wire

/* hdl/sba_pkg.sv */
// SBA shared types
// vector types for DMI and system bus values, DMI register map and the
// bus access FSM states

`default_nettype none

package sba_pkg;

`include "sba_config.svh"

   typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
   typedef logic [`SBA_ADDR_W-1:0] sba_addr_t;
   typedef logic [`SBA_DATA_W-1:0] sba_word_t;

   // debug module registers reachable over DMI
   typedef enum logic [`DMI_ADDR_W-1:0] {
      SBCS       = 7'h38,
      SBADDRESS0 = 7'h39,
      SBDATA0    = 7'h3C
   } dmi_reg_e;

   // one system bus access
   typedef enum logic [1:0] {
      SBA_IDLE,
      SBA_REQ,
      SBA_WAIT
   } sba_state_e;

endpackage

`default_nettype wire

/* hdl/sba_sram.sv */
// SBA preload SRAM
// word-addressed single-port memory, write in the request cycle and a
// response strobe one cycle after every request

`timescale 1ns/10ps
`default_nettype none
`include "sba_config.svh"

module sba_sram (
   input  logic   clk_sys,
   input  logic   rst_n_i,
   sba_bus_if.mem bus
);

   localparam int unsigned idx_w = $clog2(`SBA_MEM_WORDS);
   localparam int unsigned off_w = $clog2(`SBA_DATA_W / 8);

   sba_pkg::sba_word_t mem [`SBA_MEM_WORDS];
   sba_pkg::sba_word_t rdata_q;
   logic               rvalid_q;
   logic [idx_w-1:0]   word_idx;

   // drop the byte offset
   assign word_idx = bus.mem_addr[idx_w+off_w-1:off_w];

   always_ff @(posedge clk_sys) begin
      if (bus.mem_req) begin
         if (bus.mem_we) begin
            mem[word_idx] <= bus.mem_wdata;
         end else begin
            rdata_q <= mem[word_idx];
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= bus.mem_req;
      end
   end

   assign bus.mem_rdata  = rdata_q;
   assign bus.mem_rvalid = rvalid_q;

   a_addr_in_range: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      bus.mem_req |-> bus.mem_addr < `SBA_MEM_WORDS * (`SBA_DATA_W / 8));

endmodule

`default_nettype wire

/* include/sba_config.svh */
// SBA subsystem configuration
// widths of the system bus and DMI, and the depth of the preload SRAM

`ifndef SBA_CONFIG_SVH
`define SBA_CONFIG_SVH

// system bus byte address width
`define SBA_ADDR_W 32

// system bus data word width
`define SBA_DATA_W 32

// SRAM depth in words
`define SBA_MEM_WORDS 256

// DMI register address width
`define DMI_ADDR_W 7

`endif

/* verif/tb_dm_sba.sv */
// SBA subsystem testbench
// drives DMI register accesses into dm_sba_top and checks every response
// against a model of the SBA registers and the preload memory

`timescale 1ns/10ps
`default_nettype none
`include "sba_config.svh"

module tb_dm_sba;

   localparam int unsigned rvalid_limit = 8;
   localparam int unsigned poll_limit   = 32;
   localparam int unsigned mem_words    = `SBA_MEM_WORDS;

   logic               clk_sys;
   logic               rst_n_i;
   logic               dmi_req;
   logic               dmi_we;
   sba_pkg::dmi_addr_t dmi_addr;
   sba_pkg::sba_word_t dmi_wdata;
   sba_pkg::sba_word_t dmi_rdata_o;
   logic               dmi_rvalid_o;

   // model of memory and SBA registers
   sba_pkg::sba_word_t model_mem [sba_pkg::sba_addr_t];
   sba_pkg::sba_addr_t model_addr;
   sba_pkg::sba_word_t model_sbdata;
   logic               model_readonaddr;
   logic               model_readondata;
   logic               model_autoinc;
   logic               model_busyerror;
   logic               model_sberror;

   int unsigned check_count;
   int unsigned error_count;

   dm_sba_top dut0 (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n_i),
      .dmi_req_i    (dmi_req),
      .dmi_we_i     (dmi_we),
      .dmi_addr_i   (dmi_addr),
      .dmi_wdata_i  (dmi_wdata),
      .dmi_rdata_o  (dmi_rdata_o),
      .dmi_rvalid_o (dmi_rvalid_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #20 clk_sys = ~clk_sys;
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count = check_count + 1;
      if (got !== exp) begin
         error_count = error_count + 1;
         $display("** Error at %0t: %s: got %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      error_count = error_count + 1;
      $display("timeout at %0t: %s", $time, what);
      $display("checks: %0d, errors: %0d, timeouts: 1", check_count, error_count);
      $display("Test FAILED");
      $finish;
   endtask

   function automatic logic addr_ok(input sba_pkg::sba_addr_t a);
      return (a[1:0] == 2'b00) && (a < mem_words * 4);
   endfunction

   function automatic sba_pkg::sba_word_t expected_sbcs();
      sba_pkg::sba_word_t v;
      v = '0;
      v[22] = model_busyerror;
      v[20] = model_readonaddr;
      v[16] = model_autoinc;
      v[15] = model_readondata;
      // bad address error code
      v[14:12] = model_sberror ? 3'd2 : 3'd0;
      return v;
   endfunction

   // one DMI write strobe
   task automatic dmi_write(input sba_pkg::dmi_addr_t addr, input sba_pkg::sba_word_t data);
      dmi_req = 1'b1;
      dmi_we = 1'b1;
      dmi_addr = addr;
      dmi_wdata = data;
      @(posedge clk_sys);
      #2;
      dmi_req = 1'b0;
      dmi_we = 1'b0;
      check_value("no dmi response to a write", dmi_rvalid_o, 32'd0);
   endtask

   // read strobe with the response exactly one cycle later
   task automatic dmi_read(input sba_pkg::dmi_addr_t addr, output sba_pkg::sba_word_t data);
      int unsigned waited;
      dmi_req = 1'b1;
      dmi_we = 1'b0;
      dmi_addr = addr;
      dmi_wdata = '0;
      @(posedge clk_sys);
      #2;
      dmi_req = 1'b0;
      waited = 1;
      while (!dmi_rvalid_o && waited < rvalid_limit) begin
         @(posedge clk_sys);
         #2;
         waited = waited + 1;
      end
      if (!dmi_rvalid_o) begin
         report_timeout("no dmi_rvalid_o after a read strobe");
      end else begin
         check_value("dmi read latency", waited, 32'd1);
         data = dmi_rdata_o;
      end
   endtask

   task automatic poll_idle();
      sba_pkg::sba_word_t sbcs;
      int unsigned polls;
      polls = 0;
      dmi_read(sba_pkg::SBCS, sbcs);
      while (sbcs[21] && polls < poll_limit) begin
         dmi_read(sba_pkg::SBCS, sbcs);
         polls = polls + 1;
      end
      if (sbcs[21]) begin
         report_timeout("sbbusy stayed set");
      end
   endtask

   // bus read at the model address, as started by the DUT
   task automatic model_read_access();
      if (addr_ok(model_addr)) begin
         model_sbdata = model_mem[model_addr];
         if (model_autoinc) begin
            model_addr = model_addr + 4;
         end
      end else begin
         model_sberror = 1'b1;
      end
   endtask

   task automatic model_write_access();
      if (addr_ok(model_addr)) begin
         model_mem[model_addr] = model_sbdata;
         if (model_autoinc) begin
            model_addr = model_addr + 4;
         end
      end else begin
         model_sberror = 1'b1;
      end
   endtask

   task automatic write_sbcs(input logic onaddr, input logic ondata, input logic autoinc,
                             input logic clr_busyerr, input logic clr_sberr);
      sba_pkg::sba_word_t v;
      v = '0;
      v[22] = clr_busyerr;
      v[20] = onaddr;
      v[16] = autoinc;
      v[15] = ondata;
      v[14:12] = clr_sberr ? 3'd2 : 3'd0;
      dmi_write(sba_pkg::SBCS, v);
      model_readonaddr = onaddr;
      model_readondata = ondata;
      model_autoinc = autoinc;
      if (clr_busyerr) begin
         model_busyerror = 1'b0;
      end
      if (clr_sberr) begin
         model_sberror = 1'b0;
      end
   endtask

   task automatic write_address(input sba_pkg::sba_addr_t a);
      dmi_write(sba_pkg::SBADDRESS0, a);
      model_addr = a;
      if (model_readonaddr) begin
         model_read_access();
      end
      poll_idle();
   endtask

   task automatic write_data(input sba_pkg::sba_word_t d);
      dmi_write(sba_pkg::SBDATA0, d);
      model_sbdata = d;
      model_write_access();
      poll_idle();
   endtask

   task automatic read_data();
      sba_pkg::sba_word_t v;
      dmi_read(sba_pkg::SBDATA0, v);
      check_value("sbdata0", v, model_sbdata);
      if (model_readondata) begin
         model_read_access();
      end
      poll_idle();
   endtask

   task automatic read_address();
      sba_pkg::sba_word_t v;
      dmi_read(sba_pkg::SBADDRESS0, v);
      check_value("sbaddress0", v, model_addr);
   endtask

   task automatic check_sbcs();
      sba_pkg::sba_word_t v;
      dmi_read(sba_pkg::SBCS, v);
      check_value("sbcs", v & 32'h0071_F000, expected_sbcs());
   endtask

   initial begin
      sba_pkg::sba_addr_t a;
      sba_pkg::sba_word_t d1;
      sba_pkg::sba_word_t d2;
      logic               autoinc;
      int unsigned        i;

      void'($urandom(35));
      check_count = 0;
      error_count = 0;
      rst_n_i = 1'b0;
      dmi_req = 1'b0;
      dmi_we = 1'b0;
      dmi_addr = '0;
      dmi_wdata = '0;
      model_addr = '0;
      model_sbdata = '0;
      model_readonaddr = 1'b0;
      model_readondata = 1'b0;
      model_autoinc = 1'b0;
      model_busyerror = 1'b0;
      model_sberror = 1'b0;

      repeat (2) @(posedge clk_sys);
      #2;
      rst_n_i = 1'b1;
      check_sbcs();
      read_address();

      // preload the whole SRAM with autoincrement
      write_sbcs(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      write_address('0);
      for (i = 0; i < mem_words; i = i + 1) begin
         write_data($urandom);
      end
      dmi_read(sba_pkg::SBADDRESS0, d1);
      check_value("address after preload", d1, mem_words * 4);

      // read back a block through readondata
      write_sbcs(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      write_address($urandom_range(0, mem_words - 17) * 4);
      repeat (16) read_data();
      check_sbcs();

      // random single reads and writes
      for (i = 0; i < 64; i = i + 1) begin
         autoinc = ($urandom_range(0, 1) == 1);
         a = $urandom_range(0, mem_words - 2) * 4;
         if ($urandom_range(0, 1) == 1) begin
            write_sbcs(1'b0, 1'b0, autoinc, 1'b0, 1'b0);
            write_address(a);
            write_data($urandom);
         end else begin
            write_sbcs(1'b1, 1'b0, autoinc, 1'b0, 1'b0);
            write_address(a);
            read_data();
         end
         read_address();
      end

      // out of range, misaligned and read on a bad address
      write_sbcs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      write_address(mem_words * 4 + $urandom_range(0, 63) * 4);
      write_data($urandom);
      check_sbcs();
      write_sbcs(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
      check_sbcs();
      write_address($urandom_range(0, mem_words - 1) * 4 + $urandom_range(1, 3));
      write_data($urandom);
      check_sbcs();
      write_sbcs(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
      write_address(mem_words * 4 + 4);
      check_sbcs();
      write_sbcs(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
      check_sbcs();

      // second data write lands while the first access runs
      a = $urandom_range(0, mem_words - 1) * 4;
      d1 = $urandom;
      d2 = $urandom;
      write_address(a);
      dmi_write(sba_pkg::SBDATA0, d1);
      dmi_write(sba_pkg::SBDATA0, d2);
      model_sbdata = d1;
      model_write_access();
      model_busyerror = 1'b1;
      poll_idle();
      check_sbcs();
      read_data();
      write_sbcs(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
      check_sbcs();

      // sweep the whole memory against the model
      write_sbcs(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      write_address('0);
      repeat (mem_words) read_data();
      check_sbcs();

      $display("checks: %0d, errors: %0d, timeouts: 0", check_count, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
